// ==== project.f ====
+incdir+bench
rtl/secmem_pkg.sv
rtl/secmem_access_decode.sv
rtl/secmem_bank.sv
rtl/secmem_resp_queue.sv
rtl/secmem_top.sv
bench/secmem_tb.sv

// ==== Bender.yml ====
package:
  name: secmem

sources:
  - files:
      - rtl/secmem_pkg.sv
      - rtl/secmem_access_decode.sv
      - rtl/secmem_bank.sv
      - rtl/secmem_resp_queue.sv
      - rtl/secmem_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/secmem_tb.sv

// ==== bench/secmem_tests.svh ====
// Directed tests for the secure memory port, included in the testbench body.
// Each test ends with its responses drained and all credits returned.

	task automatic after_reset_idle();
		begin_test("after_reset_idle");
		repeat (10) begin
			tick();
			check_bit("resp_valid", resp_valid, 1'b0);
			check_bit("req_credit", req_credit, 1'b0);
		end
		end_test();
	endtask

	// domain 0 below the partition and domain 1 above it
	task automatic allowed_read_write();
		int lo_addr [4];
		begin_test("allowed_read_write");
		for (int i = 0; i < 4; i++) begin
			lo_addr[i] = lcg_next() % P_INIT_PARTITION;
			hi_addr[i] = P_INIT_PARTITION + lcg_next() % (2 ** ADDR_BITS - P_INIT_PARTITION);
		end
		for (int i = 0; i < 4; i++) begin
			send_req(op_write, 1'b0, lo_addr[i], lcg_next());
			send_req(op_write, 1'b1, hi_addr[i], lcg_next());
		end
		for (int i = 0; i < 4; i++) begin
			send_req(op_read, 1'b0, lo_addr[i], '0);
			send_req(op_read, 1'b1, hi_addr[i], '0);
		end
		wait_responses();
		compare_responses();
		end_test();
	endtask

	task automatic denied_low_domain();
		begin_test("denied_low_domain");
		send_req(op_write, 1'b1, P_INIT_PARTITION, lcg_next());
		send_req(op_write, 1'b1, P_INIT_PARTITION + 22, lcg_next());
		// at and above the partition
		send_req(op_read, 1'b0, P_INIT_PARTITION, '0);
		send_req(op_write, 1'b0, P_INIT_PARTITION + 22, lcg_next());
		send_req(op_write, 1'b0, P_INIT_PARTITION, lcg_next());
		// words still hold the secure data
		send_req(op_read, 1'b1, P_INIT_PARTITION, '0);
		send_req(op_read, 1'b1, P_INIT_PARTITION + 22, '0);
		wait_responses();
		compare_responses();
		end_test();
	endtask

	// new partition 200 and probe word 140 between old and new
	task automatic move_partition();
		begin_test("move_partition");
		send_req(op_set_partition, 1'b0, 200, '0);
		// lowering it is refused as well
		send_req(op_set_partition, 1'b0, 100, '0);
		send_req(op_read, 1'b0, 140, '0);
		send_req(op_set_partition, 1'b1, 200, '0);
		send_req(op_write, 1'b0, 140, lcg_next());
		send_req(op_read, 1'b0, 140, '0);
		wait_responses();
		compare_responses();
		end_test();
	endtask

	task automatic credit_backpressure();
		int early;
		int waited;
		begin_test("credit_backpressure");
		early = (P_SINK_CREDITS < P_RESP_DEPTH) ? P_SINK_CREDITS : P_RESP_DEPTH;
		auto_credit   = 1'b0;
		credit_pulses = 0;
		for (int i = 0; i < P_RESP_DEPTH; i++) begin
			send_req(op_read, 1'b1, hi_addr[i % 4], '0);
		end
		waited = 0;
		while (got_q.size() < early && waited < 40) begin
			tick();
			waited++;
		end
		// sink out of slots
		repeat (8) begin
			tick();
			check_bit("resp_valid", resp_valid, 1'b0);
		end
		if (got_q.size() != early) begin
			errors++;
			$display("expected %0d responses before sink credits came back, saw %0d",
				early, got_q.size());
		end
		// one slot back per response already taken
		repeat (early) begin
			tick();
			resp_credit = 1'b1;
		end
		auto_credit = 1'b1;
		wait_responses();
		compare_responses();
		if (credit_pulses != P_RESP_DEPTH) begin
			errors++;
			$display("expected %0d request credits back, counted %0d",
				P_RESP_DEPTH, credit_pulses);
		end
		end_test();
	endtask

// ==== bench/secmem_tb.sv ====
// Directed testbench for the secure memory port, default parameters only.
// Keeps its own request credits and a model of memory and partition.
// Tests read only words they wrote earlier.

`timescale 1ns/1ns

module secmem_tb;

	import secmem_pkg::*;

	localparam int CLK_PERIOD       = 40;
	localparam int P_RESP_DEPTH     = 4;
	localparam int P_SINK_CREDITS   = 2;
	localparam int P_INIT_PARTITION = 128;
	// requests issued by all tests together
	localparam int TOTAL_REQS       = 29 + P_RESP_DEPTH;

	logic      clk;
	logic      reset;
	logic      req_valid;
	mem_req_t  req;
	logic      req_credit;
	logic      resp_valid;
	mem_resp_t resp;
	logic      resp_credit;

	// ====================
	// model and bookkeeping
	// ====================

	logic [DATA_BITS-1:0]   model_mem [int];
	int                     model_part;
	int                     hi_addr [4];
	mem_resp_t              exp_q [$];
	mem_resp_t              got_q [$];
	int                     credits;
	int                     credit_pulses;
	bit                     auto_credit;
	logic [OPAQUE_BITS-1:0] next_tag;
	logic [31:0]            lcg_state;
	string                  test_name;
	int                     test_err_start;
	int                     checks;
	int                     errors;
	int                     tests_run;
	int                     tests_failed;

	secmem_top #(
		.P_RESP_DEPTH     (P_RESP_DEPTH),
		.P_SINK_CREDITS   (P_SINK_CREDITS),
		.P_INIT_PARTITION (P_INIT_PARTITION)
	) secmem_top_i (
		.clk         (clk),
		.reset       (reset),
		.req_valid   (req_valid),
		.req         (req),
		.req_credit  (req_credit),
		.resp_valid  (resp_valid),
		.resp        (resp),
		.resp_credit (resp_credit)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TOTAL_REQS * 20 * CLK_PERIOD);
		$display("watchdog expired after %0d ns, run stopped", TOTAL_REQS * 20 * CLK_PERIOD);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// expected response by the domain rules and model update
	function automatic mem_resp_t model_access(mem_req_t r);
		mem_resp_t exp;
		bit        ok;
		ok = r.domain || (int'(r.addr) < model_part && r.opcode != op_set_partition);
		exp.opcode = r.opcode;
		exp.opaque = r.opaque;
		exp.status = ok ? resp_ok : resp_denied;
		exp.data   = '0;
		if (ok && r.opcode == op_write) begin
			model_mem[int'(r.addr)] = r.data;
		end
		if (ok && r.opcode == op_read) begin
			exp.data = model_mem[int'(r.addr)];
		end
		if (ok && r.opcode == op_set_partition) begin
			model_part = int'(r.addr);
		end
		return exp;
	endfunction

	task automatic check_resp(string name, mem_resp_t got, mem_resp_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	// sample outputs at the falling edge and clear the pulses
	task automatic tick();
		@(negedge clk);
		if (resp_valid === 1'b1) begin
			got_q.push_back(resp);
		end
		if (req_credit === 1'b1) begin
			credits++;
			credit_pulses++;
		end
		req_valid   = 1'b0;
		resp_credit = 1'b0;
		if (resp_valid === 1'b1 && auto_credit) begin
			resp_credit = 1'b1;
		end
	endtask

	task automatic send_req(mem_op_e op, logic dom, int addr, logic [DATA_BITS-1:0] data);
		mem_req_t r;
		tick();
		while (credits == 0) begin
			tick();
		end
		r.opcode = op;
		r.domain = dom;
		r.opaque = next_tag;
		r.addr   = ADDR_BITS'(addr);
		r.data   = data;
		next_tag++;
		credits--;
		exp_q.push_back(model_access(r));
		req       = r;
		req_valid = 1'b1;
	endtask

	task automatic wait_responses();
		int limit;
		limit = 20 * exp_q.size() + 20;
		while (got_q.size() < exp_q.size() && limit > 0) begin
			tick();
			limit--;
		end
		if (got_q.size() < exp_q.size()) begin
			errors++;
			$display("timed out waiting for responses, %0d of %0d arrived",
				got_q.size(), exp_q.size());
		end
	endtask

	// responses must come back in request order
	task automatic compare_responses();
		while (exp_q.size() > 0 && got_q.size() > 0) begin
			check_resp("resp", got_q.pop_front(), exp_q.pop_front());
		end
		if (exp_q.size() != 0 || got_q.size() != 0) begin
			errors++;
			$display("response count wrong, %0d missing and %0d extra",
				exp_q.size(), got_q.size());
		end
		exp_q.delete();
		got_q.delete();
	endtask

	task automatic begin_test(string name);
		test_name      = name;
		test_err_start = errors;
		tests_run++;
	endtask

	task automatic end_test();
		if (errors == test_err_start) begin
			$display("test %-20s ok", test_name);
		end else begin
			tests_failed++;
			$display("test %-20s fail, %0d errors", test_name, errors - test_err_start);
		end
	endtask

	`include "secmem_tests.svh"

	initial begin
		reset       = 1'b1;
		req_valid   = 1'b0;
		req         = '0;
		resp_credit = 1'b0;
		model_part    = P_INIT_PARTITION;
		credits       = P_RESP_DEPTH;
		credit_pulses = 0;
		auto_credit   = 1'b1;
		next_tag      = '0;
		lcg_state     = 32'd90897;
		checks        = 0;
		errors        = 0;
		tests_run     = 0;
		tests_failed  = 0;
		repeat (4) @(negedge clk);
		reset = 1'b0;

		after_reset_idle();
		allowed_read_write();
		denied_low_domain();
		move_partition();
		credit_backpressure();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== rtl/secmem_top.sv ====
// Secure memory port. Credit flow control both ways, no ready signals.
// Responses return in request order, at least 3 cycles after the request.

`timescale 1ns/1ns

module secmem_top #(
	parameter int P_RESP_DEPTH     = 4,
	parameter int P_SINK_CREDITS   = 2,
	parameter int P_INIT_PARTITION = 128,
	parameter int P_ADDR_BITS      = secmem_pkg::ADDR_BITS
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  req_valid,
	input  secmem_pkg::mem_req_t  req,
	output logic                  req_credit,

	output logic                  resp_valid,
	output secmem_pkg::mem_resp_t resp,
	input  logic                  resp_credit
);

	import secmem_pkg::*;

	logic      cmd_valid;
	bank_cmd_t cmd;

	logic      bank_valid;
	mem_resp_t bank_resp;

	//====================
	// stages
	//====================

	secmem_access_decode #(
		.P_INIT_PARTITION (P_INIT_PARTITION),
		.P_ADDR_BITS      (P_ADDR_BITS)
	) decode_i (
		.clk       (clk),
		.reset     (reset),
		.req_valid (req_valid),
		.req       (req),
		.cmd_valid (cmd_valid),
		.cmd       (cmd)
	);

	secmem_bank #(
		.P_ADDR_BITS (P_ADDR_BITS)
	) bank_i (
		.clk        (clk),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.resp_valid (bank_valid),
		.resp       (bank_resp)
	);

	secmem_resp_queue #(
		.P_RESP_DEPTH   (P_RESP_DEPTH),
		.P_SINK_CREDITS (P_SINK_CREDITS)
	) queue_i (
		.clk         (clk),
		.reset       (reset),
		.push_valid  (bank_valid),
		.push        (bank_resp),
		.resp_credit (resp_credit),
		.resp_valid  (resp_valid),
		.resp        (resp),
		.req_credit  (req_credit)
	);

endmodule

// ==== rtl/secmem_resp_queue.sv ====
// Response FIFO with sink credits. Both depths must be at least 1.
// An empty queue forwards a push to the output on the next edge.

`timescale 1ns/1ns

module secmem_resp_queue #(
	parameter int P_RESP_DEPTH   = 4,
	parameter int P_SINK_CREDITS = 2
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  push_valid,
	input  secmem_pkg::mem_resp_t push,

	input  logic                  resp_credit,
	output logic                  resp_valid,
	output secmem_pkg::mem_resp_t resp,
	output logic                  req_credit
);

	import secmem_pkg::*;

	localparam int PTR_BITS = (P_RESP_DEPTH > 1) ? $clog2(P_RESP_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(P_RESP_DEPTH + 1);
	localparam int CRD_BITS = $clog2(P_SINK_CREDITS + 1);

	mem_resp_t slots [P_RESP_DEPTH];

	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [CNT_BITS-1:0] count;
	logic [CRD_BITS-1:0] sink_credits;

	mem_resp_t head;
	logic      avail;
	logic      pop;

	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(P_RESP_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// bypass when nothing is stored
	assign head  = (count == '0) ? push : slots[rd_ptr];
	assign avail = push_valid || count != '0;
	assign pop   = avail && sink_credits != '0;

	//====================
	// storage
	//====================

	always_ff @(posedge clk) begin
		if (push_valid) begin
			slots[wr_ptr] <= push;
		end
		if (pop) begin
			resp <= head;
		end
	end

	//====================
	// pointers and credits
	//====================

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			count        <= '0;
			sink_credits <= CRD_BITS'(P_SINK_CREDITS);
			resp_valid   <= 1'b0;
		end else begin
			resp_valid <= pop;
			if (push_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count        <= count + CNT_BITS'(push_valid) - CNT_BITS'(pop);
			sink_credits <= sink_credits + CRD_BITS'(resp_credit) - CRD_BITS'(pop);
		end
	end

	// one request credit back per response leaving
	assign req_credit = resp_valid;

	// requester credits cap what can be in flight
	assert property (@(posedge clk) disable iff (reset)
		push_valid |-> count != CNT_BITS'(P_RESP_DEPTH));

	// sink never returns more slots than it was given
	assert property (@(posedge clk) disable iff (reset)
		resp_credit |-> pop || sink_credits != CRD_BITS'(P_SINK_CREDITS));

endmodule

// ==== rtl/secmem_bank.sv ====
// Single-port word memory, one command per cycle, response one cycle later.
// Contents are undefined until written; there is no clear.

`timescale 1ns/1ns

module secmem_bank #(
	parameter int P_ADDR_BITS = secmem_pkg::ADDR_BITS
) (
	input  logic                  clk,

	input  logic                  cmd_valid,
	input  secmem_pkg::bank_cmd_t cmd,

	output logic                  resp_valid,
	output secmem_pkg::mem_resp_t resp
);

	import secmem_pkg::*;

	localparam int WORDS = 2 ** P_ADDR_BITS;

	logic [DATA_BITS-1:0] mem [WORDS];

	logic [P_ADDR_BITS-1:0] word;
	logic                   do_write;
	logic                   do_read;

	assign word     = cmd.req.addr[P_ADDR_BITS-1:0];
	assign do_write = cmd_valid && cmd.granted && cmd.req.opcode == op_write;
	assign do_read  = cmd_valid && cmd.granted && cmd.req.opcode == op_read;

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[word] <= cmd.req.data;
		end
	end

	// valid tracks the decode stage one edge behind
	always_ff @(posedge clk) begin
		resp_valid <= cmd_valid;
	end

	always_ff @(posedge clk) begin
		resp.opcode <= cmd.req.opcode;
		resp.opaque <= cmd.req.opaque;
		resp.status <= cmd.granted ? resp_ok : resp_denied;
		// denied and non-read ops return zero
		resp.data   <= do_read ? mem[word] : '0;
	end

endmodule

// ==== rtl/secmem_access_decode.sv ====
// Domain check and request register. P_ADDR_BITS must not exceed ADDR_BITS.
// Domain 0 is checked on the full address; the secure domain wraps high bits.

`timescale 1ns/1ns

module secmem_access_decode #(
	parameter int P_INIT_PARTITION = 128,
	parameter int P_ADDR_BITS      = secmem_pkg::ADDR_BITS
) (
	input  logic                  clk,
	input  logic                  reset,

	input  logic                  req_valid,
	input  secmem_pkg::mem_req_t  req,

	output logic                  cmd_valid,
	output secmem_pkg::bank_cmd_t cmd
);

	import secmem_pkg::*;

	// words below this are open to domain 0
	logic [P_ADDR_BITS-1:0] partition;

	logic below_partition;
	logic granted;
	logic set_partition;

	assign below_partition = req.addr < ADDR_BITS'(partition);

	// secure domain sees everything, domain 0 only the low region
	// and never the partition itself
	assign granted = req.domain
		|| (below_partition && req.opcode != op_set_partition);

	assign set_partition = req_valid && granted && req.opcode == op_set_partition;

	//====================
	// partition register
	//====================

	always_ff @(posedge clk) begin
		if (reset) begin
			partition <= P_ADDR_BITS'(P_INIT_PARTITION);
		end else if (set_partition) begin
			// takes effect for the next request
			partition <= req.addr[P_ADDR_BITS-1:0];
		end
	end

	//====================
	// request register
	//====================

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= req_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid) begin
			cmd.req     <= req;
			cmd.granted <= granted;
		end
	end

endmodule

// ==== rtl/secmem_pkg.sv ====
// Shared request, response and command types for the secure memory port.
// Field widths here are fixed; a narrower memory uses the low address bits.

package secmem_pkg;

	//====================
	// default widths
	//====================

	// word address width, default for P_ADDR_BITS
	localparam int ADDR_BITS = 8;

	localparam int DATA_BITS = 32;

	// tag carried by a request and echoed back in its response
	localparam int OPAQUE_BITS = 8;

	//====================
	// encodings
	//====================

	typedef enum logic [1:0] {
		op_read          = 2'b00,
		op_write         = 2'b01,
		// addr field carries the new partition
		op_set_partition = 2'b10
	} mem_op_e;

	typedef enum logic {
		resp_ok     = 1'b0,
		resp_denied = 1'b1
	} resp_status_e;

	//====================
	// messages
	//====================

	// 51 bits. domain 1 is secure
	typedef struct packed {
		mem_op_e                opcode;
		logic                   domain;
		logic [OPAQUE_BITS-1:0] opaque;
		logic [ADDR_BITS-1:0]   addr;
		logic [DATA_BITS-1:0]   data;
	} mem_req_t;

	// 43 bits. data is zero unless a granted read
	typedef struct packed {
		mem_op_e                opcode;
		resp_status_e           status;
		logic [OPAQUE_BITS-1:0] opaque;
		logic [DATA_BITS-1:0]   data;
	} mem_resp_t;

	// decode to bank, request plus the access verdict
	typedef struct packed {
		mem_req_t req;
		logic     granted;
	} bank_cmd_t;

endpackage
